// ==== source/krlt_pkg.sv ====
//**********************************************************************
// address map, reset values and field layouts of the link-training CSR
// lane count is fixed at four because the map is built around it
// struct fields are listed msb first, so bit 0 is the last member
//**********************************************************************
package krlt_pkg;

  localparam int num_lanes = 4;

  //********************************************************************
  // register addresses
  //********************************************************************
  localparam logic [7:0] addr_base    = 8'hC0;
  localparam logic [7:0] addr_reset   = 8'hC1;  // lane commands + tuning
  localparam logic [7:0] addr_status  = 8'hC2;  // read only
  localparam logic [7:0] addr_bertim0 = 8'hC3;
  localparam logic [7:0] addr_bertim1 = 8'hC4;
  localparam logic [7:0] addr_bertim2 = 8'hC5;
  localparam logic [7:0] addr_bertim3 = 8'hC6;
  localparam logic [7:0] addr_coef0   = 8'hC7;  // read only
  localparam logic [7:0] addr_coef1   = 8'hC8;
  localparam logic [7:0] addr_coef2   = 8'hC9;
  localparam logic [7:0] addr_coef3   = 8'hCA;

  //********************************************************************
  // register layouts
  //********************************************************************
  typedef struct packed {
    logic [2:0] max_post_step;
    logic       max_mode;
    logic       fixed_mode;
    logic [2:0] rx_dfe_mode;
    logic       only_inc_main;
    logic [2:0] rx_ctle_mode;
    logic [1:0] ctle_depth;
    logic       ovrd_coef_rx;
    logic       ovrd_lp_coef;
    logic       dis_init_pma;
    logic [2:0] equal_cnt;
    logic [3:0] prpo_step_cnt;
    logic [3:0] main_step_cnt;
    logic       pass_one;
    logic       quick_mode;
    logic       dis_max_wait_tmr;
    logic       lt_enable;
  } krlt_base_t;

  // upper part of the reset register, bits 24:16
  typedef struct packed {
    logic       use_full_time;
    logic       dec_post;
    logic [2:0] ctle_bias;
    logic       ctle_pass_ber;
    logic       dec_post_more;
    logic [1:0] dfe_extra;
  } krlt_tune_t;

  // lower part of the reset register, one bit per lane in each field
  typedef struct packed {
    logic [3:0] ovrd_rx_new;
    logic [3:0] lp_tx_upd_new;
    logic [3:0] reset_lt;
  } lane_cmd_t;

  typedef struct packed {
    logic [9:0] ber_m_time;
    logic [9:0] ber_k_time;
    logic [9:0] ber_time;
  } ber_time_t;

  typedef struct packed {
    logic fail_ctle;
    logic nolock_rxeq;
    logic train_lock_err;
    logic training_error;
    logic training_fail;
    logic training;
    logic lt_frame_lock;
    logic rx_trained;
  } lane_status_t;

  typedef logic [7:0] coef_update_t;
  typedef logic [6:0] coef_status_t;

  //********************************************************************
  // reset values
  //********************************************************************
  localparam krlt_base_t base_reset      = 32'h8008_5111;  // lt on, eq cnt 5
  localparam krlt_tune_t tune_reset      = 9'h050;         // ctle bias 5
  localparam ber_time_t  ber_default_sim = 30'h3;          // 3 frames
  localparam ber_time_t  ber_default_hw  = 30'h3C00;       // 15k frames

  // internal register access, one request per bus transfer
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [7:0]  addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } reg_rsp_t;

endpackage

// ==== source/krlt_apb_slave.sv ====
//**********************************************************************
// APB slave with zero wait states, pready is tied high
// prdata and pslverr are registered in setup and held for the access
// phase only, both read zero at any other time
//**********************************************************************
`timescale 1ns/1ps

module krlt_apb_slave (
  input  logic               clk,
  input  logic               reset,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  logic [7:0]         paddr,
  input  logic [31:0]        pwdata,
  output logic [31:0]        prdata,
  output logic               pready,
  output logic               pslverr,
  output krlt_pkg::reg_req_t req,
  input  krlt_pkg::reg_rsp_t rsp
);

  logic setup;  // first cycle of a transfer

  assign setup     = psel & ~penable;
  assign pready    = 1'b1;
  assign req.rd    = setup & ~pwrite;           // read data sampled in setup
  assign req.wr    = psel & penable & pwrite;   // write lands at end of access
  assign req.addr  = paddr;
  assign req.wdata = pwdata;

  // the address decode is valid from setup, so a write error is known
  // one cycle before the write strobe and shows during its access phase
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end else if (setup) begin
      prdata  <= rsp.rdata;  // already zero for writes and bad addresses
      pslverr <= rsp.err;
    end else begin
      prdata  <= '0;
      pslverr <= 1'b0;
    end
  end

endmodule

// ==== source/krlt_status_capture.sv ====
//**********************************************************************
// samples a per-lane payload on the rising edge of its "new" flag
// flag goes through a two-flop synchronizer, payload is taken as is,
// so it must hold steady around the flag edge
//**********************************************************************
`timescale 1ns/1ps

module krlt_status_capture #(
  parameter type payload_t = logic [7:0]
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic     [krlt_pkg::num_lanes-1:0]     new_flag,
  input  payload_t [krlt_pkg::num_lanes-1:0]     payload,
  output payload_t [krlt_pkg::num_lanes-1:0]     latched
);

  logic [krlt_pkg::num_lanes-1:0] flag_meta;  // first sync stage
  logic [krlt_pkg::num_lanes-1:0] flag_sync;
  logic [krlt_pkg::num_lanes-1:0] flag_dly;   // for edge detect
  logic [krlt_pkg::num_lanes-1:0] flag_rise;

  assign flag_rise = flag_sync & ~flag_dly;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      flag_meta <= '0;
      flag_sync <= '0;
      flag_dly  <= '0;
      latched   <= '0;
    end else begin
      flag_meta <= new_flag;
      flag_sync <= flag_meta;
      flag_dly  <= flag_sync;
      for (int n = 0; n < krlt_pkg::num_lanes; n++) begin
        if (flag_rise[n]) begin
          latched[n] <= payload[n];
        end
      end
    end
  end

endmodule

// ==== source/krlt_regfile.sv ====
//**********************************************************************
// register storage, address decode and read mux
// response is combinational on the request, err depends on addr only
// writes to the status and coef words are dropped without an error
//**********************************************************************
`timescale 1ns/1ps

module krlt_regfile #(
  parameter krlt_pkg::ber_time_t ber_default = krlt_pkg::ber_default_sim
) (
  input  logic                                              clk,
  input  logic                                              reset,
  input  krlt_pkg::reg_req_t                                req,
  input  krlt_pkg::lane_status_t [krlt_pkg::num_lanes-1:0]  lane_status,
  input  krlt_pkg::coef_update_t [krlt_pkg::num_lanes-1:0]  lcl_upd,
  input  krlt_pkg::coef_update_t [krlt_pkg::num_lanes-1:0]  lp_upd,
  input  krlt_pkg::coef_status_t [krlt_pkg::num_lanes-1:0]  lcl_stat,
  input  krlt_pkg::coef_status_t [krlt_pkg::num_lanes-1:0]  lp_stat,
  input  krlt_pkg::lane_cmd_t                               cmd_now,
  output krlt_pkg::reg_rsp_t                                rsp,
  output krlt_pkg::krlt_base_t                              base,
  output krlt_pkg::krlt_tune_t                              tune,
  output krlt_pkg::ber_time_t    [krlt_pkg::num_lanes-1:0]  ber,
  output logic                                              cmd_wr,
  output krlt_pkg::lane_cmd_t                               cmd_data
);

  logic [1:0]  ber_idx;   // lane of a BER time access
  logic [1:0]  coef_idx;  // lane of a coef word access
  logic        hit_base;
  logic        hit_reset;
  logic        hit_ber;
  logic        hit_coef;
  logic [31:0] rd_word;

  assign ber_idx   = 2'(req.addr - krlt_pkg::addr_bertim0);
  assign coef_idx  = 2'(req.addr - krlt_pkg::addr_coef0);
  assign hit_base  = (req.addr == krlt_pkg::addr_base);
  assign hit_reset = (req.addr == krlt_pkg::addr_reset);
  assign hit_ber   = req.addr inside {[krlt_pkg::addr_bertim0 : krlt_pkg::addr_bertim3]};
  assign hit_coef  = req.addr inside {[krlt_pkg::addr_coef0 : krlt_pkg::addr_coef3]};

  //********************************************************************
  // read mux
  //********************************************************************
  always_comb begin
    rd_word = '0;
    rsp.err = 1'b0;
    if (hit_base) begin
      rd_word = base;
    end else if (hit_reset) begin
      rd_word[11:0]  = cmd_now;  // live command bits, not the written value
      rd_word[24:16] = tune;
    end else if (req.addr == krlt_pkg::addr_status) begin
      rd_word = lane_status;     // lane n in byte n
    end else if (hit_ber) begin
      rd_word[29:0] = ber[ber_idx];
    end else if (hit_coef) begin
      rd_word[7:0]   = lcl_upd[coef_idx];
      rd_word[14:8]  = lcl_stat[coef_idx];
      rd_word[23:16] = lp_upd[coef_idx];
      rd_word[30:24] = lp_stat[coef_idx];
    end else begin
      rsp.err = 1'b1;            // unmapped, rd_word stays zero
    end
    rsp.rdata = req.rd ? rd_word : '0;
  end

  //********************************************************************
  // register writes
  //********************************************************************
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      base <= krlt_pkg::base_reset;
      tune <= krlt_pkg::tune_reset;
      for (int n = 0; n < krlt_pkg::num_lanes; n++) begin
        ber[n] <= ber_default;
      end
    end else if (req.wr) begin
      if (hit_base) begin
        base <= req.wdata;
      end
      if (hit_reset) begin
        tune <= req.wdata[24:16];
      end
      if (hit_ber) begin
        ber[ber_idx] <= req.wdata[29:0];
      end
    end
  end

  // command bits live in krlt_lane_cmd, which owns the self-clear
  assign cmd_wr   = req.wr & hit_reset;
  assign cmd_data = req.wdata[11:0];

endmodule

// ==== source/krlt_lane_cmd.sv ====
//**********************************************************************
// self-clearing lane commands, each written bit is high two cycles
// a new write replaces all bits and restarts the clear timer
//**********************************************************************
`timescale 1ns/1ps

module krlt_lane_cmd (
  input  logic                clk,
  input  logic                reset,
  input  logic                cmd_wr,
  input  krlt_pkg::lane_cmd_t cmd_data,
  output krlt_pkg::lane_cmd_t cmd
);

  logic [1:0] clr_tmr;  // shifts toward bit 0, clear when bit 0 is set

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmd     <= '0;
      clr_tmr <= '0;
    end else if (cmd_wr) begin
      cmd     <= cmd_data;
      clr_tmr <= {|cmd_data, 1'b0};  // no timer for an all-zero write
    end else begin
      clr_tmr <= {1'b0, clr_tmr[1]};
      if (clr_tmr[0]) begin
        cmd <= '0;
      end
    end
  end

endmodule

// ==== source/krlt_csr_top.sv ====
//**********************************************************************
// link-training CSR block on APB, four lanes
// ber_default sets the BER time reset value, sim or full-length
//**********************************************************************
`timescale 1ns/1ps

module krlt_csr_top #(
  parameter krlt_pkg::ber_time_t ber_default = krlt_pkg::ber_default_sim
) (
  input  logic                                              clk,
  input  logic                                              reset,
  // APB
  input  logic                                              psel,
  input  logic                                              penable,
  input  logic                                              pwrite,
  input  logic [7:0]                                        paddr,
  input  logic [31:0]                                       pwdata,
  output logic [31:0]                                       prdata,
  output logic                                              pready,
  output logic                                              pslverr,
  // training engine status
  input  krlt_pkg::lane_status_t [krlt_pkg::num_lanes-1:0]  lane_status,
  input  logic                   [krlt_pkg::num_lanes-1:0]  lcl_tx_upd_new,
  input  logic                   [krlt_pkg::num_lanes-1:0]  lcl_tx_stat_new,
  input  logic                   [krlt_pkg::num_lanes-1:0]  lp_rx_upd_new,
  input  logic                   [krlt_pkg::num_lanes-1:0]  lp_rx_stat_new,
  input  krlt_pkg::coef_update_t [krlt_pkg::num_lanes-1:0]  lcl_txi_update,
  input  krlt_pkg::coef_status_t [krlt_pkg::num_lanes-1:0]  lcl_txi_status,
  input  krlt_pkg::coef_update_t [krlt_pkg::num_lanes-1:0]  lp_rxi_update,
  input  krlt_pkg::coef_status_t [krlt_pkg::num_lanes-1:0]  lp_rxi_status,
  // control outputs
  output krlt_pkg::krlt_base_t                              base,
  output krlt_pkg::krlt_tune_t                              tune,
  output krlt_pkg::ber_time_t    [krlt_pkg::num_lanes-1:0]  ber,
  output krlt_pkg::lane_cmd_t                               cmd
);

  krlt_pkg::reg_req_t                                req;
  krlt_pkg::reg_rsp_t                                rsp;
  krlt_pkg::coef_update_t [krlt_pkg::num_lanes-1:0]  lcl_upd;
  krlt_pkg::coef_update_t [krlt_pkg::num_lanes-1:0]  lp_upd;
  krlt_pkg::coef_status_t [krlt_pkg::num_lanes-1:0]  lcl_stat;
  krlt_pkg::coef_status_t [krlt_pkg::num_lanes-1:0]  lp_stat;
  logic                                              cmd_wr;
  krlt_pkg::lane_cmd_t                               cmd_data;

  krlt_apb_slave u_apb_slave (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .req, .rsp
  );

  krlt_status_capture #(.payload_t(krlt_pkg::coef_update_t)) u_lcl_upd_cap (
    .clk, .reset, .new_flag(lcl_tx_upd_new), .payload(lcl_txi_update), .latched(lcl_upd)
  );
  krlt_status_capture #(.payload_t(krlt_pkg::coef_status_t)) u_lcl_stat_cap (
    .clk, .reset, .new_flag(lcl_tx_stat_new), .payload(lcl_txi_status), .latched(lcl_stat)
  );
  krlt_status_capture #(.payload_t(krlt_pkg::coef_update_t)) u_lp_upd_cap (
    .clk, .reset, .new_flag(lp_rx_upd_new), .payload(lp_rxi_update), .latched(lp_upd)
  );
  krlt_status_capture #(.payload_t(krlt_pkg::coef_status_t)) u_lp_stat_cap (
    .clk, .reset, .new_flag(lp_rx_stat_new), .payload(lp_rxi_status), .latched(lp_stat)
  );

  krlt_regfile #(.ber_default(ber_default)) u_regfile (
    .clk, .reset, .req, .lane_status, .lcl_upd, .lp_upd, .lcl_stat, .lp_stat,
    .cmd_now(cmd), .rsp, .base, .tune, .ber, .cmd_wr, .cmd_data
  );

  krlt_lane_cmd u_lane_cmd (
    .clk, .reset, .cmd_wr, .cmd_data, .cmd
  );

endmodule

// ==== verif/krlt_csr_checker.sv ====
//**********************************************************************
// APB response and lane command assertions, bound into krlt_csr_top
// the command check assumes no rewrite of a bit while it is still high
//**********************************************************************
`timescale 1ns/1ps

module krlt_csr_checker (
  input logic        clk,
  input logic        reset,
  input logic        psel,
  input logic        penable,
  input logic        pslverr,
  input logic [31:0] prdata,
  input logic [11:0] cmd_bits
);

  // an error response belongs to the access phase only
  err_in_access: assert property (@(posedge clk) disable iff (reset)
      pslverr |-> (psel && penable))
    else $error("pslverr high outside the APB access phase");

  err_zero_data: assert property (@(posedge clk) disable iff (reset)
      pslverr |-> (prdata == '0))
    else $error("prdata not zero with pslverr high");

  // no command bit may stay high for four samples in a row
  cmd_self_clear: assert property (@(posedge clk) disable iff (reset)
      !(|(cmd_bits & $past(cmd_bits) & $past(cmd_bits, 2) & $past(cmd_bits, 3))))
    else $error("lane command bit not cleared within three cycles");

endmodule

bind krlt_csr_top krlt_csr_checker u_checker (
  .clk(clk), .reset(reset), .psel(psel), .penable(penable),
  .pslverr(pslverr), .prdata(prdata), .cmd_bits(cmd)
);

// ==== verif/krlt_csr_tb.sv ====
//**********************************************************************
// directed APB tests of the link-training CSR block
// expects the sim BER default 30'h3 and zero wait states
//**********************************************************************
`timescale 1ns/1ps

module krlt_csr_tb;

  localparam int max_cycles = 3000;  // tests take about 160 cycles

  logic        clk;
  logic        reset;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [3:0]  flags;  // drives all four "new" flag vectors
  krlt_pkg::lane_status_t [3:0] lane_status;
  krlt_pkg::coef_update_t [3:0] lcl_upd;
  krlt_pkg::coef_status_t [3:0] lcl_stat;
  krlt_pkg::coef_update_t [3:0] lp_upd;
  krlt_pkg::coef_status_t [3:0] lp_stat;
  krlt_pkg::krlt_base_t         base;
  krlt_pkg::krlt_tune_t         tune;
  krlt_pkg::ber_time_t    [3:0] ber;
  krlt_pkg::lane_cmd_t          cmd;

  int          checks;
  int          errors;
  int          test_start;  // error count when the current test began
  int          cycle_cnt;
  logic [31:0] rd;
  logic        err;
  logic [31:0] base_exp;
  logic [31:0] coef_next [4];  // coef words for the payloads now driven

  krlt_csr_top u_krlt_csr_top (
    .clk, .reset, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .lane_status, .lcl_tx_upd_new(flags), .lcl_tx_stat_new(flags),
    .lp_rx_upd_new(flags), .lp_rx_stat_new(flags),
    .lcl_txi_update(lcl_upd), .lcl_txi_status(lcl_stat),
    .lp_rxi_update(lp_upd), .lp_rxi_status(lp_stat),
    .base, .tune, .ber, .cmd
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //********************************************************************
  // bus and check helpers
  //********************************************************************
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  // one transfer, returns 2 ns after the edge that ends the access phase
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic slverr);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    compare_value("pready", 32'(pready), 32'h1);  // zero wait states
    rdata  = prdata;  // stable through the access phase
    slverr = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr,
                             input logic [31:0] exp);
    apb_xfer(1'b0, addr, 32'h0, rd, err);
    compare_value({"prdata ", name}, rd, exp);
    compare_value({"pslverr ", name}, 32'(err), 32'h0);
  endtask

  task automatic write_ok(input logic [7:0] addr, input logic [31:0] data);
    apb_xfer(1'b1, addr, data, rd, err);
    compare_value("pslverr on write", 32'(err), 32'h0);
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d mismatches", name, errors - test_start);
    test_start = errors;
  endtask

  // coef word n: lcl update 7:0, lcl status 14:8, lp update 23:16, lp status 30:24
  task automatic new_payloads();
    @(posedge clk);
    #2;
    for (int n = 0; n < 4; n++) begin
      lcl_upd[n]   = 8'($urandom);
      lcl_stat[n]  = 7'($urandom);
      lp_upd[n]    = 8'($urandom);
      lp_stat[n]   = 7'($urandom);
      coef_next[n] = {1'b0, lp_stat[n], lp_upd[n], 1'b0, lcl_stat[n], lcl_upd[n]};
    end
  endtask

  //********************************************************************
  // directed tests
  //********************************************************************
  task automatic test_reset_values();
    compare_value("prdata idle", prdata, 32'h0);
    compare_value("pslverr idle", 32'(pslverr), 32'h0);
    read_expect("base", 8'hC0, 32'h8008_5111);
    read_expect("reset reg", 8'hC1, 32'h0050_0000);  // ctle bias 5 at bits 22:20
    for (int n = 0; n < 4; n++) begin
      read_expect("ber time", 8'(8'hC3 + n), 32'h3);
      compare_value("ber", 32'(ber[n]), 32'h3);
    end
    compare_value("base", base, 32'h8008_5111);
    compare_value("tune", 32'(tune), 32'h050);
    compare_value("cmd", 32'(cmd), 32'h0);
    end_test("reset_values");
  endtask

  task automatic test_reg_rw();
    logic [31:0] wdata;
    logic [31:0] ber_wr [4];
    wdata    = $urandom;
    base_exp = wdata;
    write_ok(8'hC0, wdata);
    read_expect("base", 8'hC0, wdata);
    compare_value("base.lt_enable", 32'(base.lt_enable), 32'(wdata[0]));
    compare_value("base.main_step_cnt", 32'(base.main_step_cnt), 32'(wdata[7:4]));
    compare_value("base.equal_cnt", 32'(base.equal_cnt), 32'(wdata[14:12]));
    compare_value("base.rx_ctle_mode", 32'(base.rx_ctle_mode), 32'(wdata[22:20]));
    compare_value("base.rx_dfe_mode", 32'(base.rx_dfe_mode), 32'(wdata[26:24]));
    compare_value("base.max_post_step", 32'(base.max_post_step), 32'(wdata[31:29]));
    for (int n = 0; n < 4; n++) begin
      ber_wr[n] = $urandom;  // bits 31:30 are not stored
      write_ok(8'(8'hC3 + n), ber_wr[n]);
    end
    for (int n = 0; n < 4; n++) begin
      read_expect("ber time", 8'(8'hC3 + n), {2'b00, ber_wr[n][29:0]});
      compare_value("ber.ber_time", 32'(ber[n].ber_time), 32'(ber_wr[n][9:0]));
      compare_value("ber.ber_k_time", 32'(ber[n].ber_k_time), 32'(ber_wr[n][19:10]));
      compare_value("ber.ber_m_time", 32'(ber[n].ber_m_time), 32'(ber_wr[n][29:20]));
    end
    end_test("reg_rw");
  endtask

  task automatic test_lane_cmd();
    logic [31:0] wdata;
    logic [11:0] cmd_val;
    logic [8:0]  tune_val;
    cmd_val        = 12'($urandom) | 12'h001;
    tune_val       = 9'($urandom);
    wdata          = $urandom;
    wdata[11:0]    = cmd_val;
    wdata[24:16]   = tune_val;
    write_ok(8'hC1, wdata);
    compare_value("cmd", 32'(cmd), 32'(cmd_val));
    compare_value("cmd.reset_lt", 32'(cmd.reset_lt), 32'(cmd_val[3:0]));
    compare_value("cmd.ovrd_rx_new", 32'(cmd.ovrd_rx_new), 32'(cmd_val[11:8]));
    @(posedge clk);
    #2;
    compare_value("cmd", 32'(cmd), 32'(cmd_val));  // second cycle high
    @(posedge clk);
    #2;
    compare_value("cmd", 32'(cmd), 32'h0);
    repeat (2) @(posedge clk);
    #2;
    compare_value("cmd", 32'(cmd), 32'h0);
    compare_value("tune", 32'(tune), 32'(tune_val));
    compare_value("tune.ctle_bias", 32'(tune.ctle_bias), 32'(tune_val[6:4]));
    read_expect("reset reg", 8'hC1, {7'b0, tune_val, 16'h0});
    end_test("lane_cmd");
  endtask

  task automatic test_status();
    logic [7:0]  status_val [4];
    logic [31:0] exp;
    @(posedge clk);
    #2;
    for (int n = 0; n < 4; n++) begin
      status_val[n]  = 8'($urandom);
      lane_status[n] = status_val[n];
    end
    exp = {status_val[3], status_val[2], status_val[1], status_val[0]};
    read_expect("status", 8'hC2, exp);
    write_ok(8'hC2, ~exp);  // read only, dropped quietly
    read_expect("status", 8'hC2, exp);
    end_test("status");
  endtask

  task automatic test_coef_capture();
    logic [31:0] coef_old [4];
    new_payloads();
    flags = 4'hF;
    repeat (5) @(posedge clk);
    for (int n = 0; n < 4; n++) begin
      read_expect("coef", 8'(8'hC7 + n), coef_next[n]);
      coef_old[n] = coef_next[n];
    end
    new_payloads();  // flags still high, no new edge
    repeat (5) @(posedge clk);
    for (int n = 0; n < 4; n++) begin
      read_expect("coef held", 8'(8'hC7 + n), coef_old[n]);
    end
    flags = 4'h0;
    repeat (4) @(posedge clk);
    #2;
    flags = 4'hF;
    repeat (5) @(posedge clk);
    for (int n = 0; n < 4; n++) begin
      read_expect("coef new", 8'(8'hC7 + n), coef_next[n]);
    end
    end_test("coef_capture");
  endtask

  task automatic test_bad_addr();
    logic [7:0] bad [2];
    bad[0] = 8'h00;
    bad[1] = 8'hCB;
    for (int i = 0; i < 2; i++) begin
      apb_xfer(1'b0, bad[i], 32'h0, rd, err);
      compare_value("pslverr on bad read", 32'(err), 32'h1);
      compare_value("prdata on bad read", rd, 32'h0);
      apb_xfer(1'b1, bad[i], $urandom, rd, err);
      compare_value("pslverr on bad write", 32'(err), 32'h1);
      compare_value("prdata on bad write", rd, 32'h0);
    end
    read_expect("base", 8'hC0, base_exp);
    end_test("bad_addr");
  endtask

  //********************************************************************
  // run
  //********************************************************************
  initial begin
    void'($urandom(32'h25f5_6f2e));
    checks      = 0;
    errors      = 0;
    test_start  = 0;
    reset       = 1'b1;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = 8'h00;
    pwdata      = 32'h0;
    flags       = 4'h0;
    lane_status = '0;
    lcl_upd     = '0;
    lcl_stat    = '0;
    lp_upd      = '0;
    lp_stat     = '0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;
    test_reset_values();
    test_reg_rw();
    test_lane_cmd();
    test_status();
    test_coef_capture();
    test_bad_addr();
    $display("%0d checks, %0d mismatches", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles", max_cycles);
    $display("test failed");
    $finish;
  end

endmodule

// ==== krlt_csr_top.f ====
source/krlt_pkg.sv
source/krlt_apb_slave.sv
source/krlt_status_capture.sv
source/krlt_regfile.sv
source/krlt_lane_cmd.sv
source/krlt_csr_top.sv
verif/krlt_csr_checker.sv
verif/krlt_csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the CSR testbench, output goes to sim.log
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module krlt_csr_tb -f krlt_csr_top.f \
  || { echo "verilator build failed"; exit 1; }

# a model that stops on an assertion exits nonzero and counts as a failure
./obj_dir/Vkrlt_csr_tb > sim.log 2>&1 || echo "test failed" >> sim.log
cat sim.log

grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
